// ==== design/div_dispatch.sv ====
// divide request dispatcher

`timescale 1ns/10ps

`include "div_settings.svh"

module div_dispatch (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid_i,
    input  div_pkg::div_req_t    req_i,
    input  logic                 int_assert_i,
    input  div_pkg::lane_mask_t  lane_busy_i,
    output logic                 stall_o,
    output div_pkg::lane_mask_t  lane_start_o,
    output div_pkg::div_req_t    lane_req_o
);

    logic                req_live;
    logic                any_free;
    logic                buf_full;
    logic                buf_load;
    logic                pending;
    div_pkg::div_req_t   buf_req;
    div_pkg::lane_mask_t free_pick;

    // an interrupt in the same cycle kills the request
    assign req_live = req_valid_i && !int_assert_i;

    assign any_free = |(~lane_busy_i);

    // lowest index lane that is not busy
    always_comb begin
        free_pick = '0;
        for (int i = `DIV_LANES - 1; i >= 0; i--) begin
            if (!lane_busy_i[i]) begin
                free_pick    = '0;
                free_pick[i] = 1'b1;
            end
        end
    end

    // buffered request always goes first
    assign pending    = buf_full || req_live;
    assign lane_req_o = buf_full ? buf_req : req_i;

    assign lane_start_o = pending ? free_pick : '0;

    // a live request behind a full buffer must be presented again
    assign stall_o = buf_full && req_live;

    assign buf_load = !buf_full && req_live && !any_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_full <= 1'b0;
        end else if (buf_full) begin
            // drained into a lane at this edge
            if (any_free) begin
                buf_full <= 1'b0;
            end
        end else if (buf_load) begin
            buf_full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            buf_req <= req_i;
        end
    end

    // stalled request comes back unchanged on the next cycle
    a_stall_repeat: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_o |=> req_valid_i && $stable(req_i)
    );

    // a started lane reports busy from the next cycle on
    a_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        lane_start_o != '0 |=> (lane_busy_i & $past(lane_start_o)) == $past(lane_start_o)
    );

endmodule

// ==== design/div_lane.sv ====
// iterative radix-2 divider lane

`timescale 1ns/10ps

`include "div_settings.svh"

module div_lane (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  div_pkg::div_req_t  req_i,
    input  logic               grant_i,
    output logic               busy_o,
    output logic               done_o,
    output div_pkg::div_wb_t   wb_o
);

    localparam int CNT_W = $clog2(`DIV_ITER);

    div_pkg::lane_state_e  state;
    logic [CNT_W-1:0]      cnt;

    div_pkg::xlen_t        quo;
    div_pkg::xlen_t        rem;
    div_pkg::xlen_t        dvsr;
    div_pkg::reg_addr_t    waddr;
    div_pkg::commit_id_t   cid;
    logic                  is_rem;
    logic                  neg_quo;
    logic                  neg_rem;
    logic                  div_zero;
    logic                  ovf;

    logic                  signed_op;
    logic                  a_neg;
    logic                  b_neg;
    div_pkg::xlen_t        abs_a;
    div_pkg::xlen_t        abs_b;
    logic [`DIV_XLEN:0]    rem_shift;
    logic [`DIV_XLEN:0]    diff;
    div_pkg::xlen_t        quo_fix;
    div_pkg::xlen_t        rem_fix;
    div_pkg::xlen_t        result;

    // operand prep on start
    assign signed_op = (req_i.op == div_pkg::OP_DIV) || (req_i.op == div_pkg::OP_REM);
    assign a_neg     = signed_op && req_i.dividend[`DIV_XLEN-1];
    assign b_neg     = signed_op && req_i.divisor[`DIV_XLEN-1];
    assign abs_a     = a_neg ? -req_i.dividend : req_i.dividend;
    assign abs_b     = b_neg ? -req_i.divisor : req_i.divisor;

    // restoring step, one quotient bit
    assign rem_shift = {rem, quo[`DIV_XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvsr};

    // sign fixup and riscv special results
    assign quo_fix = neg_quo ? -quo : quo;
    assign rem_fix = neg_rem ? -rem : rem;

    always_comb begin
        if (div_zero) begin
            // remainder fixup restores the original dividend here
            result = is_rem ? rem_fix : '1;
        end else if (ovf) begin
            result = is_rem ? '0 : {1'b1, {(`DIV_XLEN-1){1'b0}}};
        end else begin
            result = is_rem ? rem_fix : quo_fix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= div_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                div_pkg::IDLE: begin
                    if (start_i) begin
                        state <= div_pkg::CALC;
                        cnt   <= '0;
                    end
                end
                div_pkg::CALC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`DIV_ITER - 1)) begin
                        state <= div_pkg::FIX;
                    end
                end
                div_pkg::FIX: begin
                    state <= div_pkg::DONE;
                end
                default: begin
                    // hold result until writeback takes it
                    if (grant_i) begin
                        state <= div_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_pkg::IDLE && start_i) begin
            quo      <= abs_a;
            rem      <= '0;
            dvsr     <= abs_b;
            waddr    <= req_i.waddr;
            cid      <= req_i.commit_id;
            is_rem   <= (req_i.op == div_pkg::OP_REM) || (req_i.op == div_pkg::OP_REMU);
            neg_quo  <= a_neg ^ b_neg;
            neg_rem  <= a_neg;
            div_zero <= (req_i.divisor == '0);
            ovf      <= signed_op && (req_i.divisor == '1) &&
                        (req_i.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}});
        end else if (state == div_pkg::CALC) begin
            if (!diff[`DIV_XLEN]) begin
                rem <= diff[`DIV_XLEN-1:0];
                quo <= {quo[`DIV_XLEN-2:0], 1'b1};
            end else begin
                rem <= rem_shift[`DIV_XLEN-1:0];
                quo <= {quo[`DIV_XLEN-2:0], 1'b0};
            end
        end else if (state == div_pkg::FIX) begin
            // quotient register carries the final result
            quo <= result;
        end
    end

    assign busy_o = (state != div_pkg::IDLE);
    assign done_o = (state == div_pkg::DONE);
    assign wb_o   = '{wdata: quo, waddr: waddr, commit_id: cid};

    // dispatcher must only pick an idle lane
    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        start_i |-> state == div_pkg::IDLE
    );

    a_grant_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant_i |-> state == div_pkg::DONE
    );

endmodule

// ==== design/div_pkg.sv ====
// divide unit shared types

`include "div_settings.svh"

package div_pkg;

    typedef logic [`DIV_XLEN-1:0]    xlen_t;
    typedef logic [`DIV_RADDR_W-1:0] reg_addr_t;
    typedef logic [`DIV_CID_W-1:0]   commit_id_t;
    typedef logic [`DIV_LANES-1:0]   lane_mask_t;

    // riscv M-extension divide ops
    typedef logic [1:0] div_op_t;
    localparam div_op_t OP_DIV  = 2'd0;
    localparam div_op_t OP_DIVU = 2'd1;
    localparam div_op_t OP_REM  = 2'd2;
    localparam div_op_t OP_REMU = 2'd3;

    typedef struct packed {
        div_op_t    op;
        xlen_t      dividend;
        xlen_t      divisor;
        reg_addr_t  waddr;
        commit_id_t commit_id;
    } div_req_t;

    typedef struct packed {
        xlen_t      wdata;
        reg_addr_t  waddr;
        commit_id_t commit_id;
    } div_wb_t;

    typedef enum logic [1:0] {IDLE, CALC, FIX, DONE} lane_state_e;

endpackage

// ==== design/div_writeback.sv ====
// divide result writeback selector

`timescale 1ns/10ps

`include "div_settings.svh"

module div_writeback (
    input  logic                 clk,
    input  div_pkg::lane_mask_t  lane_done_i,
    input  div_pkg::div_wb_t     lane_wb_i [`DIV_LANES],
    input  logic                 wb_ready_i,
    output logic                 wb_we_o,
    output div_pkg::div_wb_t     wb_o,
    output div_pkg::lane_mask_t  lane_grant_o
);

    div_pkg::lane_mask_t sel;

    // fixed priority, lowest finished lane wins
    always_comb begin
        sel  = '0;
        wb_o = lane_wb_i[0];
        for (int i = `DIV_LANES - 1; i >= 0; i--) begin
            if (lane_done_i[i]) begin
                sel    = '0;
                sel[i] = 1'b1;
                wb_o   = lane_wb_i[i];
            end
        end
    end

    assign wb_we_o = |lane_done_i;

    // lane only leaves DONE when the register file takes the result
    assign lane_grant_o = wb_ready_i ? sel : '0;

    // a stalled result stays put unless another lane finishes meanwhile
    a_wb_stable: assert property (
        @(posedge clk)
        (wb_we_o && !wb_ready_i) ##1 $stable(lane_done_i) |-> $stable(wb_o)
    );

endmodule

// ==== design/exu_div.sv ====
// divide unit top level

`timescale 1ns/10ps

`include "div_settings.svh"

module exu_div (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid_i,
    input  div_pkg::div_req_t  req_i,
    input  logic               int_assert_i,
    output logic               stall_o,
    input  logic               wb_ready_i,
    output logic               wb_we_o,
    output div_pkg::div_wb_t   wb_o
);

    div_pkg::lane_mask_t lane_busy;
    div_pkg::lane_mask_t lane_start;
    div_pkg::lane_mask_t lane_done;
    div_pkg::lane_mask_t lane_grant;
    div_pkg::div_req_t   lane_req;
    div_pkg::div_wb_t    lane_wb [`DIV_LANES];

    div_dispatch u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .lane_busy_i  (lane_busy),
        .stall_o      (stall_o),
        .lane_start_o (lane_start),
        .lane_req_o   (lane_req)
    );

    // all lanes share the dispatched request, start picks one
    for (genvar g = 0; g < `DIV_LANES; g++) begin : g_lane
        div_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .start_i (lane_start[g]),
            .req_i   (lane_req),
            .grant_i (lane_grant[g]),
            .busy_o  (lane_busy[g]),
            .done_o  (lane_done[g]),
            .wb_o    (lane_wb[g])
        );
    end

    div_writeback u_writeback (
        .clk          (clk),
        .lane_done_i  (lane_done),
        .lane_wb_i    (lane_wb),
        .wb_ready_i   (wb_ready_i),
        .wb_we_o      (wb_we_o),
        .wb_o         (wb_o),
        .lane_grant_o (lane_grant)
    );

endmodule

// ==== include/div_settings.svh ====
// divide unit build settings

`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and result width
`define DIV_XLEN 32

// number of identical divider lanes, 1 to 4
`define DIV_LANES 2

// destination register index width
`define DIV_RADDR_W 5

// instruction tag width
`define DIV_CID_W 3

// one quotient bit per cycle
`define DIV_ITER `DIV_XLEN

`endif

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_exu_div -f sim.f || exit 1
out=$(./obj_dir/Vtb_exu_div)
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1

// ==== sim.f ====
+incdir+include
design/div_pkg.sv
design/div_dispatch.sv
design/div_lane.sv
design/div_writeback.sv
design/exu_div.sv
test/div_checker.sv
test/tb_exu_div.sv

// ==== test/div_checker.sv ====
// divide result checker

`timescale 1ns/10ps

`include "div_settings.svh"

module div_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid_i,
    input  div_pkg::div_req_t  req_i,
    input  logic               int_assert_i,
    input  logic               stall_i,
    input  logic               wb_ready_i,
    input  logic               wb_we_i,
    input  div_pkg::div_wb_t   wb_i,
    output int                 err_count_o,
    output int                 pending_o
);

    localparam int NUM_IDS = 1 << `DIV_CID_W;

    logic               exp_valid [NUM_IDS];
    div_pkg::xlen_t     exp_data  [NUM_IDS];
    div_pkg::reg_addr_t exp_waddr [NUM_IDS];
    int                 errors = 0;
    int                 outstanding = 0;

    assign err_count_o = errors;
    assign pending_o   = outstanding;

    // riscv M-extension results with divide by zero and signed overflow
    function automatic div_pkg::xlen_t model_result(input div_pkg::div_req_t r);
        logic signed [`DIV_XLEN-1:0] sa;
        logic signed [`DIV_XLEN-1:0] sb;
        div_pkg::xlen_t              min_neg;
        div_pkg::xlen_t              result;
        logic                        by_zero;
        logic                        overflow;
        sa       = r.dividend;
        sb       = r.divisor;
        min_neg  = {1'b1, {(`DIV_XLEN-1){1'b0}}};
        by_zero  = (r.divisor == '0);
        overflow = (r.dividend == min_neg) && (r.divisor == '1);
        case (r.op)
            div_pkg::OP_DIV:  result = by_zero ? '1 :
                                       (overflow ? min_neg : div_pkg::xlen_t'(sa / sb));
            div_pkg::OP_DIVU: result = by_zero ? '1 : r.dividend / r.divisor;
            div_pkg::OP_REM:  result = by_zero ? r.dividend :
                                       (overflow ? '0 : div_pkg::xlen_t'(sa % sb));
            default:          result = by_zero ? r.dividend : r.dividend % r.divisor;
        endcase
        return result;
    endfunction

    task automatic check_writeback(input div_pkg::div_wb_t wb);
        if (!exp_valid[wb.commit_id]) begin
            errors++;
            $display("%0t: unexpected writeback for commit id %0d, nothing outstanding",
                     $time, wb.commit_id);
        end else begin
            if (wb.wdata !== exp_data[wb.commit_id]) begin
                errors++;
                $display("MISMATCH %0t wb_o.wdata (commit id %0d): expected %h, actual %h",
                         $time, wb.commit_id, exp_data[wb.commit_id], wb.wdata);
            end
            if (wb.waddr !== exp_waddr[wb.commit_id]) begin
                errors++;
                $display("MISMATCH %0t wb_o.waddr (commit id %0d): expected %0d, actual %0d",
                         $time, wb.commit_id, exp_waddr[wb.commit_id], wb.waddr);
            end
            exp_valid[wb.commit_id] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic record_request(input div_pkg::div_req_t r);
        if (exp_valid[r.commit_id]) begin
            errors++;
            $display("%0t: commit id %0d accepted again before its result came back",
                     $time, r.commit_id);
        end else begin
            outstanding++;
        end
        exp_valid[r.commit_id] = 1'b1;
        exp_data[r.commit_id]  = model_result(r);
        exp_waddr[r.commit_id] = r.waddr;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                exp_valid[i] = 1'b0;
            end
            outstanding = 0;
        end else begin
            // retire first so a tag freed at this edge can be taken again
            if (wb_we_i && wb_ready_i) begin
                check_writeback(wb_i);
            end
            if (req_valid_i && !int_assert_i && !stall_i) begin
                record_request(req_i);
            end
        end
    end

endmodule

// ==== test/tb_exu_div.sv ====
// divide unit testbench

`timescale 1ns/10ps

`include "div_settings.svh"

module tb_exu_div;

    localparam int TIMEOUT = 2000;

    logic                clk;
    logic                rst_n;
    logic                req_valid_i;
    div_pkg::div_req_t   req_i;
    logic                int_assert_i;
    logic                stall_o;
    logic                wb_ready_i;
    logic                wb_we_o;
    div_pkg::div_wb_t    wb_o;
    int                  err_count;
    int                  pending;

    logic [31:0]         lcg_state = 32'hf2a2_b618;
    logic                ready_random = 1'b0;
    logic                stall_at_edge = 1'b0;
    logic                xfer_at_edge = 1'b0;
    logic                stall_seen = 1'b0;
    logic                hung = 1'b0;
    div_pkg::commit_id_t next_cid = '0;
    int                  pass_count = 0;
    int                  fail_count = 0;

    exu_div UUT (.*);

    div_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .int_assert_i (int_assert_i),
        .stall_i      (stall_o),
        .wb_ready_i   (wb_ready_i),
        .wb_we_i      (wb_we_o),
        .wb_i         (wb_o),
        .err_count_o  (err_count),
        .pending_o    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // full range words mixed with small magnitudes of either sign
    function automatic div_pkg::xlen_t rand_operand();
        logic [31:0] raw;
        logic [31:0] sel;
        raw = lcg_next();
        sel = lcg_next();
        if (sel[31]) begin
            return div_pkg::xlen_t'(raw);
        end
        return div_pkg::xlen_t'($signed(raw) >>> sel[20:16]);
    endfunction

    // outputs sampled at the edge, inputs driven just after it
    task automatic tick();
        @(posedge clk);
        stall_at_edge = stall_o;
        xfer_at_edge  = wb_we_o && wb_ready_i;
        if (stall_o) begin
            stall_seen = 1'b1;
        end
        #1;
        if (ready_random) begin
            wb_ready_i = ((lcg_next() >> 16) % 100) < 30;
        end
    endtask

    // same request is repeated while the unit stalls
    task automatic send_req(input div_pkg::div_op_t op, input div_pkg::xlen_t a,
                            input div_pkg::xlen_t b, input logic kill);
        int waited;
        req_valid_i  = 1'b1;
        int_assert_i = kill;
        req_i        = '{op: op, dividend: a, divisor: b,
                         waddr: div_pkg::reg_addr_t'(lcg_next() >> 20), commit_id: next_cid};
        waited = 0;
        tick();
        while (stall_at_edge && !hung) begin
            if (waited == TIMEOUT) begin
                hung = 1'b1;
                $display("%0t: timeout, commit id %0d never accepted", $time, next_cid);
            end else begin
                tick();
                waited++;
            end
        end
        next_cid++;
        req_valid_i  = 1'b0;
        int_assert_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        ready_random = 1'b0;
        wb_ready_i   = 1'b1;
        waited       = 0;
        while (pending != 0 && !hung) begin
            if (waited == TIMEOUT) begin
                hung = 1'b1;
                $display("%0t: timeout, %0d results never written back", $time, pending);
            end else begin
                tick();
                waited++;
            end
        end
        // quiet window catches late or stray writebacks
        for (int i = 0; i < 2 * (`DIV_ITER + 2); i++) begin
            tick();
        end
    endtask

    task automatic finish_test(input string name, input int errs_before, input logic ok);
        if (ok && !hung && err_count == errs_before && pending == 0) begin
            pass_count++;
            $display("%0t: test %s ok", $time, name);
        end else begin
            fail_count++;
            $display("%0t: test %s FAILED", $time, name);
        end
    endtask

    task automatic test_reset_latency();
        int   errs;
        int   cycles;
        logic ok;
        errs = err_count;
        ok   = 1'b1;
        // requests strobed during reset must not stall or write back
        req_valid_i = 1'b1;
        for (int i = 0; i < 8; i++) begin
            tick();
            if (wb_we_o || stall_o) begin
                ok = 1'b0;
                $display("%0t: wb_we_o or stall_o high during reset", $time);
            end
        end
        rst_n       = 1'b1;
        req_valid_i = 1'b0;
        tick();
        send_req(div_pkg::OP_DIVU, div_pkg::xlen_t'(1000), div_pkg::xlen_t'(7), 1'b0);
        cycles       = 0;
        xfer_at_edge = 1'b0;
        while (!xfer_at_edge && !hung) begin
            if (cycles == TIMEOUT) begin
                hung = 1'b1;
                $display("%0t: timeout, single request never written back", $time);
            end else begin
                tick();
                cycles++;
            end
        end
        if (!hung && cycles != `DIV_ITER + 2) begin
            ok = 1'b0;
            $display("MISMATCH %0t wb_we_o latency: expected %0d, actual %0d",
                     $time, `DIV_ITER + 2, cycles);
        end
        drain();
        finish_test("reset_latency", errs, ok);
    endtask

    // op_kind 0 signed, 1 unsigned, 2 any of the four
    task automatic run_traffic(input string name, input int count, input int op_kind,
                               input int kill_pct, input logic random_ready);
        int          errs;
        logic [31:0] sel;
        logic        kill;
        logic        ok;
        errs         = err_count;
        ok           = 1'b1;
        stall_seen   = 1'b0;
        ready_random = random_ready;
        for (int i = 0; i < count; i++) begin
            sel  = lcg_next();
            kill = ((sel >> 8) % 100) < kill_pct;
            send_req({sel[31], (op_kind == 2) ? sel[30] : op_kind[0]},
                     rand_operand(), rand_operand(), kill);
        end
        drain();
        if (random_ready && !stall_seen) begin
            ok = 1'b0;
            $display("%0t: stall_o never rose under back-pressure", $time);
        end
        finish_test(name, errs, ok);
    endtask

    task automatic test_special();
        int             errs;
        div_pkg::xlen_t min_neg;
        errs    = err_count;
        min_neg = {1'b1, {(`DIV_XLEN-1){1'b0}}};
        for (int k = 0; k < 4; k++) begin
            send_req(div_pkg::div_op_t'(k), rand_operand(), '0, 1'b0);
            send_req(div_pkg::div_op_t'(k), '0, '0, 1'b0);
            send_req(div_pkg::div_op_t'(k), min_neg, '1, 1'b0);
            send_req(div_pkg::div_op_t'(k), min_neg, div_pkg::xlen_t'(1), 1'b0);
        end
        drain();
        finish_test("special_cases", errs, 1'b1);
    endtask

    initial begin
        rst_n        = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        int_assert_i = 1'b0;
        wb_ready_i   = 1'b1;
        test_reset_latency();
        run_traffic("signed_div_rem", 200, 0, 0, 1'b0);
        run_traffic("unsigned_div_rem", 200, 1, 0, 1'b0);
        test_special();
        run_traffic("backpressure", 200, 2, 0, 1'b1);
        run_traffic("interrupt_kill", 100, 2, 25, 1'b0);
        $display("%0t: %0d tests passed, %0d tests failed", $time, pass_count, fail_count);
        if (fail_count == 0 && !hung) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
